//--- logic/ext_periph_pkg.sv
// ------------------------------
// External peripheral harness package
// Bus widths, slot windows, power domains
// ------------------------------
`default_nettype none

package ext_periph_pkg;

  // Register bus
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // Peripheral slots
  localparam int unsigned NUM_PERIPH = 4;
  localparam int unsigned SLOT_IDX_W = (NUM_PERIPH > 1) ? $clog2(NUM_PERIPH) : 1;

  localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h3008_0000;
  localparam logic [ADDR_W-1:0] PERIPH_SPAN = 32'h0000_1000;

  // Power-gated domains
  localparam int unsigned NUM_BANKS       = 2;
  localparam int unsigned NUM_EXT_DOMAINS = 1;
  localparam int unsigned ACK_LATENCY     = 15;

  // First address of a slot window
  function automatic logic [ADDR_W-1:0] periph_rule_start(input int unsigned idx);
    periph_rule_start = PERIPH_BASE + ADDR_W'(idx) * PERIPH_SPAN;
  endfunction

  // First address past a slot window
  function automatic logic [ADDR_W-1:0] periph_rule_end(input int unsigned idx);
    periph_rule_end = periph_rule_start(idx) + PERIPH_SPAN;
  endfunction

endpackage

`default_nettype wire

//--- logic/reg_bus_if.sv
// ------------------------------
// Register bus channel
// Level valid/ready request and response
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

interface reg_bus_if
  import ext_periph_pkg::*;
();

  // Request, owned by the host
  logic              valid;
  logic              write;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;

  // Response, owned by the device
  logic [DATA_W-1:0] rdata;
  logic              error;
  logic              ready;

  modport host (
    output valid, write, addr, wdata, wstrb,
    input  rdata, error, ready
  );

  modport device (
    input  valid, write, addr, wdata, wstrb,
    output rdata, error, ready
  );

endinterface

`default_nettype wire

//--- logic/periph_reg_router.sv
// ------------------------------
// Peripheral register router
// Decodes host address, steers to one slot
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module periph_reg_router
  import ext_periph_pkg::*;
#(
  parameter int unsigned NUM_PERIPH = ext_periph_pkg::NUM_PERIPH
) (
  input  logic                                clk_i,
  input  logic                                arst_n_i,

  reg_bus_if.device                           host,

  output logic [NUM_PERIPH-1:0]               slot_valid_o,
  output logic                                slot_write_o,
  output logic [ADDR_W-1:0]                   slot_addr_o,
  output logic [DATA_W-1:0]                   slot_wdata_o,
  output logic [STRB_W-1:0]                   slot_wstrb_o,
  input  logic [NUM_PERIPH-1:0][DATA_W-1:0]   slot_rdata_i,
  input  logic [NUM_PERIPH-1:0]               slot_error_i,
  input  logic [NUM_PERIPH-1:0]               slot_ready_i
);

  localparam int unsigned IDX_W = (NUM_PERIPH > 1) ? $clog2(NUM_PERIPH) : 1;

  logic             hit;
  logic [IDX_W-1:0] sel;

  // Rule lookup over the disjoint slot windows
  always_comb begin
    hit = 1'b0;
    sel = '0;
    for (int unsigned i = 0; i < NUM_PERIPH; i++) begin
      if ((host.addr >= periph_rule_start(i)) && (host.addr < periph_rule_end(i))) begin
        hit = 1'b1;
        sel = IDX_W'(i);
      end
    end
  end

  // Only the matched slot sees valid
  always_comb begin
    slot_valid_o = '0;
    if (host.valid && hit) begin
      slot_valid_o[sel] = 1'b1;
    end
  end

  // Payload goes to every slot unchanged
  assign slot_write_o = host.write;
  assign slot_addr_o  = host.addr;
  assign slot_wdata_o = host.wdata;
  assign slot_wstrb_o = host.wstrb;

  // Response mux
  always_comb begin
    if (hit) begin
      host.ready = host.valid & slot_ready_i[sel];
      host.error = host.valid & slot_error_i[sel];
      host.rdata = slot_rdata_i[sel];
    end else begin
      // No rule hit, so close the access at once with an error
      host.ready = host.valid;
      host.error = host.valid;
      host.rdata = '0;
    end
  end

  // Never more than one slot addressed
  a_one_slot_valid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(slot_valid_o)
  );

  // An error only ever answers a live request
  a_no_idle_error: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !host.valid |-> !host.error
  );

  // Host keeps its request steady while a slot stalls
  a_host_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (host.valid && !host.ready) |=>
      (host.valid && $stable(host.addr) && $stable(host.write))
  );

endmodule

`default_nettype wire

//--- logic/power_switch_ack_emu.sv
// ------------------------------
// Power switch acknowledge model
// Fixed-latency delay per switch request
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module power_switch_ack_emu
  import ext_periph_pkg::*;
#(
  parameter int unsigned ACK_LATENCY = ext_periph_pkg::ACK_LATENCY,
  parameter int unsigned NUM_BANKS_P = ext_periph_pkg::NUM_BANKS
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,

  input  logic                       cpu_switch_n_i,
  input  logic                       periph_switch_n_i,
  input  logic [NUM_BANKS_P-1:0]     bank_switch_n_i,
  input  logic [NUM_EXT_DOMAINS-1:0] ext_switch_n_i,

  output logic                       cpu_switch_ack_n_o,
  output logic                       periph_switch_ack_n_o,
  output logic [NUM_BANKS_P-1:0]     bank_switch_ack_n_o,
  output logic [NUM_EXT_DOMAINS-1:0] ext_switch_ack_n_o
);

  // Bit positions of each group in the request word
  localparam int unsigned CPU_BIT    = 0;
  localparam int unsigned PERIPH_BIT = 1;
  localparam int unsigned BANK_LSB   = 2;
  localparam int unsigned EXT_LSB    = BANK_LSB + NUM_BANKS_P;
  localparam int unsigned REQ_W      = EXT_LSB + NUM_EXT_DOMAINS;

  logic [REQ_W-1:0] req_word;
  logic [REQ_W-1:0] ack_word;

  // Each bit column is one domain's switch chain
  logic [REQ_W-1:0] chain_q [ACK_LATENCY];

  always_comb begin
    req_word                                  = '0;
    req_word[CPU_BIT]                         = cpu_switch_n_i;
    req_word[PERIPH_BIT]                      = periph_switch_n_i;
    req_word[BANK_LSB +: NUM_BANKS_P]         = bank_switch_n_i;
    req_word[EXT_LSB +: NUM_EXT_DOMAINS]      = ext_switch_n_i;
  end

  // Stages come out of reset as "switch off, no ack"
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned i = 0; i < ACK_LATENCY; i++) begin
        chain_q[i] <= '1;
      end
    end else begin
      chain_q[0] <= req_word;
      for (int unsigned i = 1; i < ACK_LATENCY; i++) begin
        chain_q[i] <= chain_q[i-1];
      end
    end
  end

  // Seen at an edge, this is the request sampled ACK_LATENCY edges before
  assign ack_word = chain_q[ACK_LATENCY-1];

  assign cpu_switch_ack_n_o    = ack_word[CPU_BIT];
  assign periph_switch_ack_n_o = ack_word[PERIPH_BIT];
  assign bank_switch_ack_n_o   = ack_word[BANK_LSB +: NUM_BANKS_P];
  assign ext_switch_ack_n_o    = ack_word[EXT_LSB +: NUM_EXT_DOMAINS];

  // At least one stage between request and ack
  a_latency_min: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ACK_LATENCY >= 1
  );

endmodule

`default_nettype wire

//--- logic/ext_periph_harness.sv
// ------------------------------
// External peripheral harness
// Register router and switch ack model
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module ext_periph_harness
  import ext_periph_pkg::*;
#(
  parameter int unsigned NUM_PERIPH  = ext_periph_pkg::NUM_PERIPH,
  parameter int unsigned ACK_LATENCY = ext_periph_pkg::ACK_LATENCY
) (
  input  logic                              clk_i,
  input  logic                              arst_n_i,

  // Host register port
  input  logic                              host_valid_i,
  input  logic                              host_write_i,
  input  logic [ADDR_W-1:0]                 host_addr_i,
  input  logic [DATA_W-1:0]                 host_wdata_i,
  input  logic [STRB_W-1:0]                 host_wstrb_i,
  output logic [DATA_W-1:0]                 host_rdata_o,
  output logic                              host_error_o,
  output logic                              host_ready_o,

  // Peripheral slots
  output logic [NUM_PERIPH-1:0]             slot_valid_o,
  output logic                              slot_write_o,
  output logic [ADDR_W-1:0]                 slot_addr_o,
  output logic [DATA_W-1:0]                 slot_wdata_o,
  output logic [STRB_W-1:0]                 slot_wstrb_o,
  input  logic [NUM_PERIPH-1:0][DATA_W-1:0] slot_rdata_i,
  input  logic [NUM_PERIPH-1:0]             slot_error_i,
  input  logic [NUM_PERIPH-1:0]             slot_ready_i,

  // Power switches, active low
  input  logic                              cpu_switch_n_i,
  input  logic                              periph_switch_n_i,
  input  logic [NUM_BANKS-1:0]              bank_switch_n_i,
  input  logic [NUM_EXT_DOMAINS-1:0]        ext_switch_n_i,
  output logic                              cpu_switch_ack_n_o,
  output logic                              periph_switch_ack_n_o,
  output logic [NUM_BANKS-1:0]              bank_switch_ack_n_o,
  output logic [NUM_EXT_DOMAINS-1:0]        ext_switch_ack_n_o
);

  reg_bus_if host_bus ();

  // Host side of the bus comes straight from the pins
  assign host_bus.valid = host_valid_i;
  assign host_bus.write = host_write_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.wdata = host_wdata_i;
  assign host_bus.wstrb = host_wstrb_i;

  assign host_rdata_o = host_bus.rdata;
  assign host_error_o = host_bus.error;
  assign host_ready_o = host_bus.ready;

  periph_reg_router #(
    .NUM_PERIPH (NUM_PERIPH)
  ) u_router (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .host         (host_bus),
    .slot_valid_o (slot_valid_o),
    .slot_write_o (slot_write_o),
    .slot_addr_o  (slot_addr_o),
    .slot_wdata_o (slot_wdata_o),
    .slot_wstrb_o (slot_wstrb_o),
    .slot_rdata_i (slot_rdata_i),
    .slot_error_i (slot_error_i),
    .slot_ready_i (slot_ready_i)
  );

  power_switch_ack_emu #(
    .ACK_LATENCY (ACK_LATENCY),
    .NUM_BANKS_P (NUM_BANKS)
  ) u_switch_ack (
    .clk_i                 (clk_i),
    .arst_n_i              (arst_n_i),
    .cpu_switch_n_i        (cpu_switch_n_i),
    .periph_switch_n_i     (periph_switch_n_i),
    .bank_switch_n_i       (bank_switch_n_i),
    .ext_switch_n_i        (ext_switch_n_i),
    .cpu_switch_ack_n_o    (cpu_switch_ack_n_o),
    .periph_switch_ack_n_o (periph_switch_ack_n_o),
    .bank_switch_ack_n_o   (bank_switch_ack_n_o),
    .ext_switch_ack_n_o    (ext_switch_ack_n_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_vectors.svh
// ------------------------------
// Register access table
// Accesses with expected slot and response
// ------------------------------
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NO_SLOT = -1;

// One host access and the response it must get
typedef struct packed {
  logic [31:0] addr;
  logic        write;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  int          slot;
  logic        error;
  logic [31:0] rdata;
} access_t;

access_t vectors [$];

task automatic add_access(input logic [31:0] addr, input logic write,
                          input logic [31:0] wdata, input logic [3:0] wstrb,
                          input int slot, input logic error, input logic [31:0] rdata);
  access_t a;
  a.addr  = addr;
  a.write = write;
  a.wdata = wdata;
  a.wstrb = wstrb;
  a.slot  = slot;
  a.error = error;
  a.rdata = rdata;
  vectors.push_back(a);
endtask

// Slot k reads back k in the top nibble and addr[15:0] below
task automatic load_vectors();
  //         addr          wr    wdata         strb  slot     err   rdata
  add_access(32'h3008_0000, 1'b0, 32'h0000_0000, 4'h0, 0,       1'b0, 32'h0000_0000);
  add_access(32'h3008_0ffc, 1'b0, 32'h0000_0000, 4'h0, 0,       1'b0, 32'h0000_0ffc);
  add_access(32'h3008_1000, 1'b0, 32'h0000_0000, 4'h0, 1,       1'b0, 32'h1000_1000);
  add_access(32'h3008_1abc, 1'b0, 32'h0000_0000, 4'h0, 1,       1'b0, 32'h1000_1abc);
  add_access(32'h3008_2004, 1'b0, 32'h0000_0000, 4'h0, 2,       1'b0, 32'h2000_2004);
  add_access(32'h3008_3ffc, 1'b0, 32'h0000_0000, 4'h0, 3,       1'b0, 32'h3000_3ffc);
  add_access(32'h3008_0010, 1'b1, 32'hdead_beef, 4'hf, 0,       1'b0, 32'h0000_0010);
  add_access(32'h3008_2100, 1'b1, 32'h1234_5678, 4'h3, 2,       1'b0, 32'h2000_2100);
  add_access(32'h3008_3008, 1'b1, 32'ha5a5_5a5a, 4'hc, 3,       1'b0, 32'h3000_3008);
  add_access(32'h3008_1ffc, 1'b1, 32'h0bad_f00d, 4'h1, 1,       1'b0, 32'h1000_1ffc);
  // Just past the last window, just below the first, and far away
  add_access(32'h3008_4000, 1'b0, 32'h0000_0000, 4'h0, NO_SLOT, 1'b1, 32'h0000_0000);
  add_access(32'h3007_fffc, 1'b0, 32'h0000_0000, 4'h0, NO_SLOT, 1'b1, 32'h0000_0000);
  add_access(32'h0000_0000, 1'b1, 32'hffff_ffff, 4'hf, NO_SLOT, 1'b1, 32'h0000_0000);
  add_access(32'hffff_fffc, 1'b0, 32'h0000_0000, 4'h0, NO_SLOT, 1'b1, 32'h0000_0000);
endtask

`endif

//--- testbench/tb_ext_periph_harness.sv
// ------------------------------
// Testbench for the peripheral harness
// Slot models, access table, switch acks
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_ext_periph_harness
  import ext_periph_pkg::*;
();

  localparam int unsigned NP            = NUM_PERIPH;
  localparam int unsigned LAT           = ACK_LATENCY;
  localparam int unsigned REQ_W         = 2 + NUM_BANKS + NUM_EXT_DOMAINS;
  localparam int          TIMEOUT       = 20;
  localparam int          SWITCH_CYCLES = 64;
  localparam logic [31:0] SEED          = 32'h7c0a1428;

  `include "tb_vectors.svh"

  logic                            clk_i;
  logic                            arst_n_i;
  logic                            host_valid_i;
  logic                            host_write_i;
  logic [ADDR_W-1:0]               host_addr_i;
  logic [DATA_W-1:0]               host_wdata_i;
  logic [STRB_W-1:0]               host_wstrb_i;
  logic [DATA_W-1:0]               host_rdata_o;
  logic                            host_error_o;
  logic                            host_ready_o;
  logic [NP-1:0]                   slot_valid_o;
  logic                            slot_write_o;
  logic [ADDR_W-1:0]               slot_addr_o;
  logic [DATA_W-1:0]               slot_wdata_o;
  logic [STRB_W-1:0]               slot_wstrb_o;
  wire  [NP-1:0][DATA_W-1:0]       slot_rdata_i;
  logic [NP-1:0]                   slot_error_i;
  logic [NP-1:0]                   slot_ready_i;
  logic                            cpu_switch_n_i;
  logic                            periph_switch_n_i;
  logic [NUM_BANKS-1:0]            bank_switch_n_i;
  logic [NUM_EXT_DOMAINS-1:0]      ext_switch_n_i;
  logic                            cpu_switch_ack_n_o;
  logic                            periph_switch_ack_n_o;
  logic [NUM_BANKS-1:0]            bank_switch_ack_n_o;
  logic [NUM_EXT_DOMAINS-1:0]      ext_switch_ack_n_o;

  int err_cnt;
  int test_cnt;
  int fail_cnt;
  int slot_wait [NP];
  int slot_delay [NP];

  ext_periph_harness #(
    .NUM_PERIPH  (NP),
    .ACK_LATENCY (LAT)
  ) u_ext_periph_harness (
    .clk_i                 (clk_i),
    .arst_n_i              (arst_n_i),
    .host_valid_i          (host_valid_i),
    .host_write_i          (host_write_i),
    .host_addr_i           (host_addr_i),
    .host_wdata_i          (host_wdata_i),
    .host_wstrb_i          (host_wstrb_i),
    .host_rdata_o          (host_rdata_o),
    .host_error_o          (host_error_o),
    .host_ready_o          (host_ready_o),
    .slot_valid_o          (slot_valid_o),
    .slot_write_o          (slot_write_o),
    .slot_addr_o           (slot_addr_o),
    .slot_wdata_o          (slot_wdata_o),
    .slot_wstrb_o          (slot_wstrb_o),
    .slot_rdata_i          (slot_rdata_i),
    .slot_error_i          (slot_error_i),
    .slot_ready_i          (slot_ready_i),
    .cpu_switch_n_i        (cpu_switch_n_i),
    .periph_switch_n_i     (periph_switch_n_i),
    .bank_switch_n_i       (bank_switch_n_i),
    .ext_switch_n_i        (ext_switch_n_i),
    .cpu_switch_ack_n_o    (cpu_switch_ack_n_o),
    .periph_switch_ack_n_o (periph_switch_ack_n_o),
    .bank_switch_ack_n_o   (bank_switch_ack_n_o),
    .ext_switch_ack_n_o    (ext_switch_ack_n_o)
  );

  always #4 clk_i = ~clk_i;

  // Slot read data follows the forwarded address
  for (genvar k = 0; k < NP; k++) begin : g_slot_rdata
    assign slot_rdata_i[k] = {4'(k), 12'h000, slot_addr_o[15:0]};
  end

  // Stall count and random delay per slot
  // Delay is redrawn after each completion
  always @(posedge clk_i or negedge arst_n_i) begin
    for (int k = 0; k < NP; k++) begin
      if (!arst_n_i) begin
        slot_wait[k]  = 0;
        slot_delay[k] = $urandom_range(3, 0);
      end else if (slot_valid_o[k] && slot_ready_i[k]) begin
        slot_wait[k]  = 0;
        slot_delay[k] = $urandom_range(3, 0);
      end else if (slot_valid_o[k]) begin
        slot_wait[k]++;
      end
    end
  end

  // Ready may sit high while idle, which gives a zero-cycle answer
  always @(negedge clk_i) begin
    for (int k = 0; k < NP; k++) begin
      slot_ready_i[k] = (slot_wait[k] >= slot_delay[k]);
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, want);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string what, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("pass  %s", what);
    end else begin
      fail_cnt++;
      $display("fail  %s", what);
    end
  endtask

  task automatic check_reset_state();
    int errs;
    errs = err_cnt;
    @(negedge clk_i);
    check_value("cpu_switch_ack_n_o", 32'(cpu_switch_ack_n_o), 32'd1);
    check_value("periph_switch_ack_n_o", 32'(periph_switch_ack_n_o), 32'd1);
    check_value("bank_switch_ack_n_o", 32'(bank_switch_ack_n_o), 32'({NUM_BANKS{1'b1}}));
    check_value("ext_switch_ack_n_o", 32'(ext_switch_ack_n_o),
                32'({NUM_EXT_DOMAINS{1'b1}}));
    @(posedge clk_i);
    check_value("slot_valid_o", 32'(slot_valid_o), 32'd0);
    check_value("host_ready_o", 32'(host_ready_o), 32'd0);
    finish_test("reset state", errs);
  endtask

  task automatic run_access(input int idx);
    access_t                 v;
    logic [SLOT_IDX_W-1:0]   sel;
    logic [NP-1:0]           exp_valid;
    int                      errs;
    int                      cyc;
    bit                      done;
    v    = vectors[idx];
    errs = err_cnt;
    sel  = SLOT_IDX_W'(v.slot);
    exp_valid = (v.slot == NO_SLOT) ? '0 : (NP'(1) << sel);
    @(negedge clk_i);
    host_valid_i = 1'b1;
    host_write_i = v.write;
    host_addr_i  = v.addr;
    host_wdata_i = v.wdata;
    host_wstrb_i = v.wstrb;
    done = 1'b0;
    cyc  = 0;
    while (!done && cyc < TIMEOUT) begin
      @(posedge clk_i);
      check_value("slot_valid_o", 32'(slot_valid_o), 32'(exp_valid));
      if (v.slot != NO_SLOT) begin
        check_value("slot_write_o", 32'(slot_write_o), 32'(v.write));
        check_value("slot_addr_o", slot_addr_o, v.addr);
        check_value("slot_wdata_o", slot_wdata_o, v.wdata);
        check_value("slot_wstrb_o", 32'(slot_wstrb_o), 32'(v.wstrb));
        // Host waits exactly as long as the slot does
        check_value("host_ready_o", 32'(host_ready_o), 32'(slot_ready_i[sel]));
      end else begin
        check_value("host_ready_o", 32'(host_ready_o), 32'd1);
      end
      if (host_ready_o) begin
        check_value("host_error_o", 32'(host_error_o), 32'(v.error));
        check_value("host_rdata_o", host_rdata_o, v.rdata);
        done = 1'b1;
      end
      cyc++;
    end
    if (!done) begin
      $display("access %0d to 0x%08h timed out waiting for host_ready_o", idx, v.addr);
      err_cnt++;
    end
    @(negedge clk_i);
    host_valid_i = 1'b0;
    @(posedge clk_i);
    check_value("slot_valid_o", 32'(slot_valid_o), 32'd0);
    check_value("host_ready_o", 32'(host_ready_o), 32'd0);
    check_value("host_error_o", 32'(host_error_o), 32'd0);
    finish_test($sformatf("access %0d %s 0x%08h", idx, v.write ? "write" : "read", v.addr),
                errs);
  endtask

  task automatic run_switch_test();
    logic [REQ_W-1:0] hist [$];
    logic [REQ_W-1:0] want;
    logic [REQ_W-1:0] req;
    int               errs;
    errs = err_cnt;
    // Requests have been high since reset
    for (int i = 0; i < LAT; i++) begin
      hist.push_back('1);
    end
    for (int c = 0; c < SWITCH_CYCLES; c++) begin
      @(negedge clk_i);
      want = hist.pop_front();
      check_value("cpu_switch_ack_n_o", 32'(cpu_switch_ack_n_o), 32'(want[0]));
      check_value("periph_switch_ack_n_o", 32'(periph_switch_ack_n_o), 32'(want[1]));
      check_value("bank_switch_ack_n_o", 32'(bank_switch_ack_n_o),
                  32'(want[2 +: NUM_BANKS]));
      check_value("ext_switch_ack_n_o", 32'(ext_switch_ack_n_o),
                  32'(want[2 + NUM_BANKS +: NUM_EXT_DOMAINS]));
      req = REQ_W'($urandom);
      {ext_switch_n_i, bank_switch_n_i, periph_switch_n_i, cpu_switch_n_i} = req;
      hist.push_back(req);
    end
    finish_test("switch acknowledge latency", errs);
  endtask

  initial begin
    void'($urandom(SEED));
    err_cnt           = 0;
    test_cnt          = 0;
    fail_cnt          = 0;
    clk_i             = 1'b0;
    arst_n_i          = 1'b0;
    host_valid_i      = 1'b0;
    host_write_i      = 1'b0;
    host_addr_i       = '0;
    host_wdata_i      = '0;
    host_wstrb_i      = '0;
    slot_error_i      = '0;
    slot_ready_i      = '0;
    cpu_switch_n_i    = 1'b1;
    periph_switch_n_i = 1'b1;
    bank_switch_n_i   = '1;
    ext_switch_n_i    = '1;
    load_vectors();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    check_reset_state();
    foreach (vectors[i]) begin
      run_access(i);
    end
    run_switch_test();
    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             test_cnt, test_cnt - fail_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+testbench
logic/ext_periph_pkg.sv
logic/reg_bus_if.sv
logic/periph_reg_router.sv
logic/power_switch_ack_emu.sv
logic/ext_periph_harness.sv
testbench/tb_ext_periph_harness.sv

//--- Makefile
TOP := tb_ext_periph_harness

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f flist.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
